//--- eeprom_cases.txt
# op (0 write, 1 read), addr, wdata, busy, expected nack, expected rdata; all hex
# busy makes the EEPROM refuse the control byte
1 123 00 0 0 22
1 7ff 00 0 0 f8
0 040 5a 0 0 00
1 040 00 0 0 5a
1 03f 00 0 0 3f
1 041 00 0 0 41
0 0a5 11 0 0 00
0 3a5 33 0 0 00
0 7a5 77 0 0 00
1 0a5 00 0 0 11
1 3a5 00 0 0 33
1 7a5 00 0 0 77
0 200 ee 1 1 00
1 200 00 1 1 00
1 200 00 0 0 02

//--- compile.f
eeprom_pkg.sv
cmd_fifo.sv
i2c_bit_engine.sv
eeprom_sequencer.sv
eeprom_subsys.sv
eeprom_bus_assert.sv
tb_eeprom_model.sv
tb_eeprom_subsys.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_eeprom_subsys
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG   ?= === FAIL ===
PASS_MSG   ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_eeprom_subsys.sv
`timescale 1ns/1ps
module tb_eeprom_subsys
    import eeprom_pkg::*;
();

    localparam int MAX_CASES       = 64;
    localparam int CYCLES_PER_CASE = 600;

    logic              CLK;
    logic              RESET;
    logic              cmd_valid;
    cmd_op_t           cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic              sda_in;
    logic              cmd_credit;
    logic              rsp_valid;
    logic              rsp_nack;
    logic [DATA_W-1:0] rsp_rdata;
    logic              scl;
    logic              dut_sda_low;
    logic              model_sda_low;
    logic              model_busy;

    logic              case_op    [MAX_CASES];
    logic [ADDR_W-1:0] case_addr  [MAX_CASES];
    logic [DATA_W-1:0] case_wdata [MAX_CASES];
    logic              case_busy  [MAX_CASES];
    logic              case_nack  [MAX_CASES];
    logic [DATA_W-1:0] case_rdata [MAX_CASES];

    int          n_cases;
    int          issued;
    int          returned;
    int          rsp_idx;
    int          n_pass;
    int          n_fail;
    int          other_errors;
    int          limit;
    logic [31:0] rng;

    assign sda_in = !(dut_sda_low || model_sda_low);   // pull-up
    // busy follows the command currently on the bus
    assign model_busy = (rsp_idx < n_cases) ? case_busy[rsp_idx] : 1'b0;

    eeprom_subsys i_dut
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .sda_in     (sda_in),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_nack   (rsp_nack),
        .rsp_rdata  (rsp_rdata),
        .scl        (scl),
        .sda_low    (dut_sda_low)
    );

    tb_eeprom_model i_model
    (
        .scl     (scl),
        .sda     (sda_in),
        .busy    (model_busy),
        .sda_low (model_sda_low)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int credits();
        return CMD_DEPTH - issued + returned;
    endfunction

    task automatic load_cases();
        int          fd;
        int          r;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_busy;
        logic [31:0] f_nack;
        logic [31:0] f_rdata;
        n_cases = 0;
        fd = $fopen("eeprom_cases.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open eeprom_cases.txt");
            other_errors++;
        end
        else
        begin
            while (!$feof(fd) && n_cases < MAX_CASES)
            begin
                line = "";
                r = $fgets(line, fd);
                if (r > 0 && line.getc(0) != 8'h23)   // skip comment lines
                begin
                    r = $sscanf(line, "%h %h %h %h %h %h",
                                f_op, f_addr, f_wdata, f_busy, f_nack, f_rdata);
                    if (r == 6)
                    begin
                        case_op[n_cases]    = f_op[0];
                        case_addr[n_cases]  = f_addr[ADDR_W-1:0];
                        case_wdata[n_cases] = f_wdata[DATA_W-1:0];
                        case_busy[n_cases]  = f_busy[0];
                        case_nack[n_cases]  = f_nack[0];
                        case_rdata[n_cases] = f_rdata[DATA_W-1:0];
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
            if (n_cases == 0)
            begin
                $display("ERROR: no cases found in eeprom_cases.txt");
                other_errors++;
            end
        end
    endtask

    // host never pushes without a credit
    task automatic run_host();
        int gap;
        for (int i = 0; i < n_cases; i++)
        begin
            rng = xorshift32(rng);
            gap = int'(rng[1:0]);
            repeat (gap)
            begin
                cmd_valid = 1'b0;
                @(negedge CLK);
            end
            while (credits() == 0)
            begin
                cmd_valid = 1'b0;
                @(negedge CLK);
            end
            cmd_valid = 1'b1;
            cmd_op    = cmd_op_t'(case_op[i]);
            cmd_addr  = case_addr[i];
            cmd_wdata = case_wdata[i];
            issued++;
            @(negedge CLK);
        end
        cmd_valid = 1'b0;
    endtask

    task automatic check_response();
        logic ok;
        ok = 1'b1;
        assert (rsp_idx < issued)
        else
        begin
            $display("ERROR: response at %0t with no command outstanding", $time);
            other_errors++;
            ok = 1'b0;
        end
        if (ok)
        begin
            assert (rsp_nack === case_nack[rsp_idx])
            else
            begin
                $display("MISMATCH t=%0t rsp_nack expected %0b got %0b",
                         $time, case_nack[rsp_idx], rsp_nack);
                ok = 1'b0;
            end
            assert (rsp_rdata === case_rdata[rsp_idx])
            else
            begin
                $display("MISMATCH t=%0t rsp_rdata expected %02h got %02h",
                         $time, case_rdata[rsp_idx], rsp_rdata);
                ok = 1'b0;
            end
            $display("case %0d %s addr %03h busy %0b: %s", rsp_idx,
                     case_op[rsp_idx] ? "read " : "write", case_addr[rsp_idx],
                     case_busy[rsp_idx], ok ? "ok" : "failed");
            if (ok)
                n_pass++;
            else
                n_fail++;
            rsp_idx++;
        end
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        if (RESET)
            returned = 0;
        else if (cmd_credit)
            returned++;
    end

    always @(negedge CLK)
    begin
        if (!RESET && rsp_valid)
            check_response();
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge CLK);
        while (cycles < limit)
        begin
            @(posedge CLK);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles, responses stopped arriving (%0d of %0d)",
                 cycles, rsp_idx, n_cases);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        RESET        = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = OP_WRITE;
        cmd_addr     = '0;
        cmd_wdata    = '0;
        issued       = 0;
        rsp_idx      = 0;
        n_pass       = 0;
        n_fail       = 0;
        other_errors = 0;
        rng          = 32'h6678_6f31;
        load_cases();
        limit = n_cases * CYCLES_PER_CASE + 200;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        run_host();
        while (rsp_idx < n_cases)
            @(negedge CLK);
        repeat (2) @(negedge CLK);
        assert (credits() == CMD_DEPTH)
        else
        begin
            $display("ERROR: host holds %0d credits after the last response, not %0d",
                     credits(), CMD_DEPTH);
            other_errors++;
        end
        $display("summary: %0d passed, %0d failed, %0d other errors",
                 n_pass, n_fail, other_errors);
        if (n_fail == 0 && other_errors == 0 && n_cases > 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- tb_eeprom_model.sv
`timescale 1ns/1ps
module tb_eeprom_model
    import eeprom_pkg::*;
(
    input  logic scl,
    input  logic sda,
    input  logic busy,
    output logic sda_low
);

    typedef enum
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_SEND
    } model_state_t;

    model_state_t      state;
    model_state_t      next_state;
    logic [DATA_W-1:0] mem [2**ADDR_W];
    logic [ADDR_W-1:0] addr;
    logic [2:0]        page;
    logic [DATA_W-1:0] shreg;
    int                bit_n;   // scl rising edges seen in the current byte

    initial
    begin
        sda_low    = 1'b0;
        state      = M_IDLE;
        next_state = M_IDLE;
        bit_n      = 0;
        addr       = '0;
        page       = '0;
        for (int a = 0; a < 2**ADDR_W; a++)
            mem[a] = a[7:0] ^ {5'b0, a[10:8]};
    end

    // start and repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state   = M_CTRL;
            bit_n   = 0;
            shreg   = '0;
            sda_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state   = M_IDLE;   // stop
            sda_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state != M_IDLE)
        begin
            if (state != M_SEND && bit_n < 8)
                shreg = {shreg[6:0], sda};
            bit_n = bit_n + 1;
        end
    end

    always @(negedge scl)
    begin
        if (state == M_SEND && bit_n < 8)
            sda_low = !mem[addr][7 - bit_n];   // msb first
        else if (state != M_IDLE && bit_n == 8)
        begin
            sda_low = 1'b0;
            case (state)
                M_CTRL:
                begin
                    if (!busy && shreg[7:4] == DEV_CODE)
                    begin
                        sda_low    = 1'b1;
                        page       = shreg[3:1];
                        next_state = shreg[0] ? M_SEND : M_ADDR;
                    end
                    else
                        state = M_IDLE;   // refused without ack
                end
                M_ADDR:
                begin
                    sda_low    = 1'b1;
                    addr       = {page, shreg};
                    next_state = M_WDATA;
                end
                M_WDATA:
                begin
                    sda_low    = 1'b1;
                    mem[addr]  = shreg;
                    next_state = M_WDATA;
                end
                default: next_state = M_IDLE;   // master nack after read byte
            endcase
        end
        else if (state != M_IDLE && bit_n == 9)
        begin
            bit_n   = 0;
            state   = next_state;
            sda_low = (state == M_SEND) ? !mem[addr][7] : 1'b0;
        end
    end

endmodule

//--- eeprom_bus_assert.sv
`timescale 1ns/1ps
module eeprom_bus_assert
    import eeprom_pkg::*;
(
    input logic             CLK,
    input logic             RESET,
    input logic             cmd_valid,
    input logic             head_pop,
    input logic [CNT_W-1:0] count,
    input logic             scl,
    input logic             sda_low,
    input bit_cmd_t         cur_cmd,
    input logic             step_done
);

    no_push_when_full: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> (count < CNT_W'(CMD_DEPTH)))
        else $error("command pushed into a full FIFO");

    no_pop_when_empty: assert property (@(posedge CLK) disable iff (RESET)
        head_pop |-> (count != '0))
        else $error("command popped from an empty FIFO");

    // sda may move with scl high only to form start or stop
    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (sda_low != $past(sda_low)) |->
            (!$past(scl) || ($past(cur_cmd) inside {BC_START, BC_STOP})))
        else $error("sda changed while scl high outside start or stop");

    single_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        step_done |=> !step_done)
        else $error("step_done high in two consecutive cycles");

endmodule

bind cmd_fifo eeprom_bus_assert i_fifo_assert
(
    .CLK       (CLK),
    .RESET     (RESET),
    .cmd_valid (cmd_valid),
    .head_pop  (head_pop),
    .count     (count),
    .scl       (1'b0),
    .sda_low   (1'b0),
    .cur_cmd   (eeprom_pkg::BC_STOP),
    .step_done (1'b0)
);

bind i2c_bit_engine eeprom_bus_assert i_bit_assert
(
    .CLK       (CLK),
    .RESET     (RESET),
    .cmd_valid (1'b0),
    .head_pop  (1'b0),
    .count     ('0),
    .scl       (scl),
    .sda_low   (sda_low),
    .cur_cmd   (cur_cmd),
    .step_done (step_done)
);

//--- eeprom_subsys.sv
`timescale 1ns/1ps
module eeprom_subsys
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    input  cmd_op_t           cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    input  logic              sda_in,
    output logic              cmd_credit,
    output logic              rsp_valid,
    output logic              rsp_nack,
    output logic [DATA_W-1:0] rsp_rdata,
    output logic              scl,
    output logic              sda_low
);

    logic              head_valid;
    cmd_op_t           head_op;
    logic [ADDR_W-1:0] head_addr;
    logic [DATA_W-1:0] head_wdata;
    logic              head_pop;
    logic              step_go;
    bit_cmd_t          step_cmd;
    logic [DATA_W-1:0] step_wdata;
    logic              step_done;
    logic              step_nack;
    logic [DATA_W-1:0] step_rdata;

    cmd_fifo i_fifo
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .head_pop   (head_pop),
        .head_valid (head_valid),
        .head_op    (head_op),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .cmd_credit (cmd_credit)
    );

    eeprom_sequencer i_seq
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .head_valid (head_valid),
        .head_op    (head_op),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .step_done  (step_done),
        .step_nack  (step_nack),
        .step_rdata (step_rdata),
        .head_pop   (head_pop),
        .step_go    (step_go),
        .step_cmd   (step_cmd),
        .step_wdata (step_wdata),
        .rsp_valid  (rsp_valid),
        .rsp_nack   (rsp_nack),
        .rsp_rdata  (rsp_rdata)
    );

    i2c_bit_engine i_bit
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .step_go    (step_go),
        .step_cmd   (step_cmd),
        .step_wdata (step_wdata),
        .sda_in     (sda_in),
        .step_done  (step_done),
        .step_nack  (step_nack),
        .step_rdata (step_rdata),
        .scl        (scl),
        .sda_low    (sda_low)
    );

endmodule

//--- eeprom_sequencer.sv
`timescale 1ns/1ps
module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              head_valid,
    input  cmd_op_t           head_op,
    input  logic [ADDR_W-1:0] head_addr,
    input  logic [DATA_W-1:0] head_wdata,
    input  logic              step_done,
    input  logic              step_nack,
    input  logic [DATA_W-1:0] step_rdata,
    output logic              head_pop,
    output logic              step_go,
    output bit_cmd_t          step_cmd,
    output logic [DATA_W-1:0] step_wdata,
    output logic              rsp_valid,
    output logic              rsp_nack,
    output logic [DATA_W-1:0] rsp_rdata
);

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_STOP,
        S_RESP
    } seq_state_t;

    seq_state_t        state;
    seq_state_t        next_state;
    logic              issued;   // step handed to the engine and awaiting done
    cmd_op_t           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              nack_q;
    logic [DATA_W-1:0] rdata_q;
    logic              refused;

    assign head_pop  = (state == S_IDLE) && head_valid;
    assign rsp_valid = (state == S_RESP);
    assign rsp_nack  = nack_q;
    assign rsp_rdata = rdata_q;
    assign refused   = (step_cmd == BC_WRITE) && step_nack;

    always_comb
    begin
        step_cmd   = BC_WRITE;
        step_wdata = '0;
        next_state = S_STOP;
        case (state)
            S_START:
            begin
                step_cmd   = BC_START;
                next_state = S_CTRL_W;
            end
            S_CTRL_W:
            begin
                step_wdata = {DEV_CODE, addr_q[ADDR_W-1:DATA_W], 1'b0};
                next_state = S_ADDR;
            end
            S_ADDR:
            begin
                step_wdata = addr_q[DATA_W-1:0];
                next_state = (op_q == OP_WRITE) ? S_DATA : S_RSTART;
            end
            S_DATA:   step_wdata = wdata_q;
            S_RSTART:
            begin
                step_cmd   = BC_START;
                next_state = S_CTRL_R;
            end
            S_CTRL_R:
            begin
                step_wdata = {DEV_CODE, addr_q[ADDR_W-1:DATA_W], 1'b1};
                next_state = S_READ;
            end
            S_READ:   step_cmd = BC_READ;
            S_STOP:
            begin
                step_cmd   = BC_STOP;
                next_state = S_RESP;
            end
            default:  ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            issued  <= 1'b0;
            step_go <= 1'b0;
        end
        else
        begin
            step_go <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (head_valid)
                        state <= S_START;
                end
                S_RESP: state <= S_IDLE;
                default:
                begin
                    if (!issued)
                    begin
                        step_go <= 1'b1;
                        issued  <= 1'b1;
                    end
                    else if (step_done)
                    begin
                        issued <= 1'b0;
                        state  <= refused ? S_STOP : next_state;   // nack ends the transfer
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (head_pop)
        begin
            op_q    <= head_op;
            addr_q  <= head_addr;
            wdata_q <= head_wdata;
            nack_q  <= 1'b0;
            rdata_q <= '0;
        end
        else if (issued && step_done)
        begin
            if (refused)
                nack_q <= 1'b1;
            if (state == S_READ)
                rdata_q <= step_rdata;
        end
    end

endmodule

//--- i2c_bit_engine.sv
`timescale 1ns/1ps
module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              step_go,
    input  bit_cmd_t          step_cmd,
    input  logic [DATA_W-1:0] step_wdata,
    input  logic              sda_in,
    output logic              step_done,
    output logic              step_nack,
    output logic [DATA_W-1:0] step_rdata,
    output logic              scl,
    output logic              sda_low
);

    bit_cmd_t          cur_cmd;
    logic              busy;
    logic [1:0]        phase;    // 0,1 scl low; 2,3 scl high
    logic [QCNT_W-1:0] qcnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic [DATA_W-1:0] shreg;
    logic              nack_q;
    logic              q_tick;
    logic              ack_bit;
    logic              last_bit;
    logic              sda_set;

    assign q_tick     = (qcnt == QCNT_W'(QUARTER - 1));
    assign ack_bit    = (bit_cnt == BIT_W'(DATA_W));
    assign last_bit   = (cur_cmd == BC_START || cur_cmd == BC_STOP) ? 1'b1 : ack_bit;
    assign step_done  = busy && q_tick && (phase == 2'd3) && last_bit;
    assign step_nack  = nack_q;
    assign step_rdata = shreg;

    // sda level driven from the middle of the low phase
    always_comb
    begin
        case (cur_cmd)
            BC_STOP:  sda_set = 1'b1;
            BC_WRITE: sda_set = !ack_bit && !shreg[DATA_W-1];
            default:  sda_set = 1'b0;   // start, read and ack bits release
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            phase   <= 2'd0;
            qcnt    <= '0;
            bit_cnt <= '0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end
        else if (!busy)
        begin
            if (step_go)
            begin
                busy    <= 1'b1;
                phase   <= 2'd0;
                qcnt    <= '0;
                bit_cnt <= '0;
                scl     <= 1'b0;
            end
        end
        else if (!q_tick)
            qcnt <= qcnt + 1'b1;
        else
        begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
            case (phase)
                2'd0: sda_low <= sda_set;
                2'd1: scl <= 1'b1;
                2'd2:
                begin
                    if (cur_cmd == BC_START)
                        sda_low <= 1'b1;   // sda falls with scl high for start
                    else if (cur_cmd == BC_STOP)
                        sda_low <= 1'b0;   // stop
                end
                default:
                begin
                    if (last_bit)
                        busy <= 1'b0;      // scl stays high
                    else
                    begin
                        scl     <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy)
        begin
            if (step_go)
            begin
                cur_cmd <= step_cmd;
                shreg   <= step_wdata;
            end
        end
        else if (q_tick)
        begin
            if (phase == 2'd2)
            begin
                // sample in the middle of scl high
                if (cur_cmd == BC_WRITE && ack_bit)
                    nack_q <= sda_in;
                else if (cur_cmd == BC_READ && !ack_bit)
                    shreg <= {shreg[DATA_W-2:0], sda_in};
            end
            else if (phase == 2'd3 && cur_cmd == BC_WRITE && !ack_bit)
                shreg <= {shreg[DATA_W-2:0], 1'b0};   // next bit msb first
        end
    end

endmodule

//--- cmd_fifo.sv
`timescale 1ns/1ps
module cmd_fifo
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    input  cmd_op_t           cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    input  logic              head_pop,
    output logic              head_valid,
    output cmd_op_t           head_op,
    output logic [ADDR_W-1:0] head_addr,
    output logic [DATA_W-1:0] head_wdata,
    output logic              cmd_credit
);

    cmd_op_t           op_mem    [CMD_DEPTH];
    logic [ADDR_W-1:0] addr_mem  [CMD_DEPTH];
    logic [DATA_W-1:0] wdata_mem [CMD_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(CMD_DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_op    = op_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];
    assign head_wdata = wdata_mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            op_mem[wr_ptr]    <= cmd_op;
            addr_mem[wr_ptr]  <= cmd_addr;
            wdata_mem[wr_ptr] <= cmd_wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            cmd_credit <= head_pop;   // one credit back per pop
            if (cmd_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (head_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({cmd_valid, head_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- eeprom_pkg.sv
package eeprom_pkg;

    // EEPROM geometry
    localparam int ADDR_W    = 11;
    localparam int DATA_W    = 8;

    // command buffer
    localparam int CMD_DEPTH = 4;
    localparam int PTR_W     = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W     = $clog2(CMD_DEPTH + 1);

    // clocks per quarter of an scl period
    localparam int QUARTER   = 2;
    localparam int QCNT_W    = $clog2(QUARTER + 1);
    localparam int BIT_W     = $clog2(DATA_W + 1);   // 8 data bits plus ack bit

    // upper nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    typedef enum logic
    {
        OP_WRITE,
        OP_READ
    } cmd_op_t;

    typedef enum logic [1:0]
    {
        BC_START,
        BC_STOP,
        BC_WRITE,
        BC_READ
    } bit_cmd_t;

endpackage
